//--- list.f
src/neoVideoPkg.sv
src/sysLatch.sv
src/palRam.sv
src/videoOut.sv
src/neoPalette.sv
tests/neoPaletteTb.sv

//--- Bender.yml
package:
  name: neo_palette

sources:
  # Package first, then the RTL in dependency order
  - src/neoVideoPkg.sv
  - src/sysLatch.sv
  - src/palRam.sv
  - src/videoOut.sv
  - src/neoPalette.sv

  # Testbench, top module neoPaletteTb
  - target: test
    files:
      - tests/neoPaletteTb.sv

//--- tests/neoPaletteTb.sv
`timescale 1ns/1ps
`default_nettype none

module neoPaletteTb;

	localparam int CLK_PERIOD = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 4;
	localparam int LATCH_OPS = 200;
	localparam int RW_OPS = 300;
	localparam int BANK_OPS = 600;
	localparam int PIX_OPS = 1500;
	localparam int COLLIDE_OPS = 40;
	localparam int DRAIN_CYCLES = 4;
	localparam int BANK_WORDS = neoVideoPkg::PAL_BANK_WORDS;
	// Cycle budget of every phase including drains
	localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + LATCH_OPS + 2 * (BANK_WORDS + 1) + 1
		+ 2 * RW_OPS + BANK_OPS + PIX_OPS + 5 * COLLIDE_OPS + 6 * DRAIN_CYCLES;
	localparam int TIMEOUT_NS = TOTAL_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD;

	logic clk;
	logic rst;
	neoVideoPkg::cpuReqT cpuReq;
	neoVideoPkg::colorWordT cpuRdData;
	logic cpuRdValid;
	logic latchWe;
	neoVideoPkg::latchAddrT latchAddr;
	logic pixStrobe;
	neoVideoPkg::pixReqT pix;
	neoVideoPkg::rgbT rgb;
	logic vidValid;
	neoVideoPkg::sysFlagsT sysFlags;

	// Reference model state
	neoVideoPkg::colorWordT modelPal [2 * BANK_WORDS];
	logic [7:0] modelFlags;
	// Pixel pipe whose stage one is the palette read
	logic s1Valid;
	neoVideoPkg::colorWordT s1Word;
	logic s1Blank;
	logic expVidValid;
	neoVideoPkg::rgbT expRgb;
	logic expRdValid;
	neoVideoPkg::colorWordT expRdData;

	logic [31:0] lcgState = 32'd54283;

	neoPalette neoPalette_inst (
		.CLK_24M    (clk),
		.rst        (rst),
		.cpuReq     (cpuReq),
		.cpuRdData  (cpuRdData),
		.cpuRdValid (cpuRdValid),
		.latchWe    (latchWe),
		.latchAddr  (latchAddr),
		.pixStrobe  (pixStrobe),
		.pix        (pix),
		.rgb        (rgb),
		.vidValid   (vidValid),
		.sysFlags   (sysFlags)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
		$display("STATUS: FAIL");
		$fatal(1, "Watchdog expired before the tests finished");
	end

	// Upper 16 bits of the LCG as the low bits cycle too fast
	function automatic logic [15:0] randWord();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	// Ladder per channel from hi nibble, LSB, not dark and not shadow
	function automatic neoVideoPkg::rgbT expectLevels(
		input logic [15:0] word,
		input logic blank,
		input logic shadow
	);
		neoVideoPkg::rgbT res;
		res = '0;
		if (!blank) begin
			res.r = {word[11:8], word[14], ~word[15], ~shadow};
			res.g = {word[7:4], word[13], ~word[15], ~shadow};
			res.b = {word[3:0], word[12], ~word[15], ~shadow};
		end
		return res;
	endfunction

	task automatic reportError(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic clearStrobes();
		cpuReq.we = 1'b0;
		cpuReq.rd = 1'b0;
		latchWe = 1'b0;
		pixStrobe = 1'b0;
	endtask

	task automatic latchWrite(input logic [2:0] sel, input logic value);
		latchWe = 1'b1;
		latchAddr = {value, sel};
	endtask

	task automatic cpuWrite(input neoVideoPkg::palIndexT addr, input logic [15:0] data);
		cpuReq.we = 1'b1;
		cpuReq.addr = addr;
		cpuReq.wrData = data;
	endtask

	task automatic cpuRead(input neoVideoPkg::palIndexT addr);
		cpuReq.rd = 1'b1;
		cpuReq.addr = addr;
	endtask

	task automatic pixelPush(input neoVideoPkg::palIndexT index, input logic blank);
		pixStrobe = 1'b1;
		pix.index = index;
		pix.blank = blank;
	endtask

	// One clock with model update at the edge, checks, then strobes drop
	task automatic tick();
		logic bnk;
		logic shadowNow;
		@(posedge clk);
		if (rst) begin
			modelFlags = '0;
			s1Valid = 1'b0;
			expVidValid = 1'b0;
			expRgb = '0;
			expRdValid = 1'b0;
		end else begin
			// Flags as they stood before this edge
			bnk = modelFlags[7];
			shadowNow = modelFlags[0];
			expVidValid = s1Valid;
			if (s1Valid)
				expRgb = expectLevels(s1Word, s1Blank, shadowNow);
			s1Valid = pixStrobe;
			if (pixStrobe) begin
				s1Word = modelPal[{bnk, pix.index}];
				s1Blank = pix.blank;
			end
			expRdValid = cpuReq.rd;
			if (cpuReq.rd)
				expRdData = modelPal[{bnk, cpuReq.addr}];
			// Reads above already took the old word
			if (cpuReq.we)
				modelPal[{bnk, cpuReq.addr}] = cpuReq.wrData;
			if (latchWe)
				modelFlags[latchAddr[2:0]] = latchAddr[3];
		end
		#(DRIVE_DELAY);
		assert (sysFlags === modelFlags)
			else reportError($sformatf("sysFlags %b, expected %b", sysFlags, modelFlags));
		assert (cpuRdValid === expRdValid)
			else reportError($sformatf("cpuRdValid %b, expected %b", cpuRdValid, expRdValid));
		if (expRdValid) begin
			assert (cpuRdData === expRdData)
				else reportError($sformatf("cpuRdData %h, expected %h", cpuRdData, expRdData));
		end
		assert (vidValid === expVidValid)
			else reportError($sformatf("vidValid %b, expected %b", vidValid, expVidValid));
		assert (rgb === expRgb)
			else reportError($sformatf("rgb %h, expected %h", rgb, expRgb));
		clearStrobes();
	endtask

	task automatic idleCycles(input int count);
		repeat (count) tick();
	endtask

	// Random latch writes each checked on the next cycle
	task automatic latchWriteSweep();
		logic [15:0] r;
		for (int i = 0; i < LATCH_OPS; i++) begin
			r = randWord();
			latchWrite(r[2:0], r[3]);
			tick();
		end
		idleCycles(DRAIN_CYCLES);
	endtask

	// Every word of bank 0 and then of bank 1
	task automatic fillBanks();
		for (int b = 0; b < 2; b++) begin
			latchWrite(3'd7, b[0]);
			tick();
			for (int i = 0; i < BANK_WORDS; i++) begin
				cpuWrite(i[11:0], randWord());
				tick();
			end
		end
		idleCycles(DRAIN_CYCLES);
	endtask

	// Writes then readback on a fixed bank
	task automatic writeThenRead();
		logic [15:0] r;
		latchWrite(3'd7, 1'b0);
		tick();
		for (int i = 0; i < RW_OPS; i++) begin
			r = randWord();
			cpuWrite(r[11:0], randWord());
			tick();
		end
		for (int i = 0; i < RW_OPS; i++) begin
			r = randWord();
			cpuRead(r[11:0]);
			tick();
		end
		idleCycles(DRAIN_CYCLES);
	endtask

	// Bank flips mixed with reads, pixels and the odd write
	task automatic bankSwitchMix();
		logic [15:0] r;
		logic [15:0] r2;
		for (int i = 0; i < BANK_OPS; i++) begin
			r = randWord();
			r2 = randWord();
			if (r[1:0] == 2'b00)
				latchWrite(3'd7, r[2]);
			if (r[3])
				cpuRead(r2[11:0]);
			else if (r[5:4] == 2'b11)
				cpuWrite(r2[11:0], randWord());
			if (r[6])
				pixelPush(r2[15:4], 1'b0);
			tick();
		end
		idleCycles(DRAIN_CYCLES);
	endtask

	// Gapped and back-to-back pixels with shadow and bank toggles
	task automatic pixelStream();
		logic [15:0] r;
		logic [15:0] r2;
		for (int i = 0; i < PIX_OPS; i++) begin
			r = randWord();
			r2 = randWord();
			if (r[7:5] == 3'b000)
				latchWrite(r[8] ? 3'd7 : 3'd0, r[9]);
			if (r[1:0] != 2'b00)
				pixelPush(r2[11:0], r[4:2] == 3'b000);
			tick();
		end
		idleCycles(DRAIN_CYCLES);
	endtask

	// Same-address write and pixel read in one cycle
	task automatic collisionPairs();
		logic [15:0] r;
		neoVideoPkg::palIndexT idx;
		logic [15:0] oldWord;
		logic [15:0] newWord;
		for (int i = 0; i < COLLIDE_OPS; i++) begin
			r = randWord();
			idx = r[11:0];
			oldWord = modelPal[{modelFlags[7], idx}];
			newWord = oldWord ^ (randWord() | 16'h0001);
			cpuWrite(idx, newWord);
			pixelPush(idx, 1'b0);
			tick();
			tick();
			assert (rgb === expectLevels(oldWord, 1'b0, modelFlags[0]))
				else reportError($sformatf("collision pixel %h, old word %h", rgb, oldWord));
			pixelPush(idx, 1'b0);
			tick();
			tick();
			assert (rgb === expectLevels(newWord, 1'b0, modelFlags[0]))
				else reportError($sformatf("later pixel %h, new word %h", rgb, newWord));
			tick();
		end
		idleCycles(DRAIN_CYCLES);
	endtask

	initial begin
		rst = 1'b1;
		cpuReq = '0;
		latchWe = 1'b0;
		latchAddr = '0;
		pixStrobe = 1'b0;
		pix = '0;
		modelFlags = '0;
		s1Valid = 1'b0;
		s1Word = '0;
		s1Blank = 1'b0;
		expVidValid = 1'b0;
		expRgb = '0;
		expRdValid = 1'b0;
		expRdData = '0;
		idleCycles(RESET_CYCLES);
		rst = 1'b0;
		// Quiet cycle straight out of reset
		tick();
		assert (sysFlags === 8'h00 && cpuRdValid === 1'b0 && vidValid === 1'b0)
			else reportError("outputs not cleared after reset");
		latchWriteSweep();
		fillBanks();
		writeThenRead();
		bankSwitchMix();
		pixelStream();
		collisionPairs();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/neoPalette.sv
`timescale 1ns/1ps
`default_nettype none

module neoPalette (
	input wire CLK_24M,
	input wire rst,
	// 68K palette port
	input wire neoVideoPkg::cpuReqT cpuReq,
	output neoVideoPkg::colorWordT cpuRdData,
	output logic cpuRdValid,
	// System latch writes, A4..A1
	input wire latchWe,
	input wire neoVideoPkg::latchAddrT latchAddr,
	// Line buffer side
	input wire pixStrobe,
	input wire neoVideoPkg::pixReqT pix,
	// Video out
	output neoVideoPkg::rgbT rgb,
	output logic vidValid,
	output neoVideoPkg::sysFlagsT sysFlags
);

	neoVideoPkg::colorWordT palWord;
	logic palValid;
	logic blankDly;

	// Blank follows the pixel through the RAM stage
	// Loaded with palWord so the pair stays together
	always_ff @(posedge CLK_24M) begin
		if (pixStrobe)
			blankDly <= pix.blank;
	end

	// Shadow, palette bank and the other control flags
	sysLatch sysLatch_inst (
		.CLK_24M   (CLK_24M),
		.rst       (rst),
		.latchWe   (latchWe),
		.latchAddr (latchAddr),
		.sysFlags  (sysFlags)
	);

	// Palette RAM, bank from latch Q7
	palRam palRam_inst (
		.CLK_24M    (CLK_24M),
		.rst        (rst),
		.bank       (sysFlags.palBnk),
		.cpuReq     (cpuReq),
		.cpuRdData  (cpuRdData),
		.cpuRdValid (cpuRdValid),
		.pixStrobe  (pixStrobe),
		.pixIndex   (pix.index),
		.palWord    (palWord),
		.palValid   (palValid)
	);

	// DAC stage
	videoOut videoOut_inst (
		.CLK_24M  (CLK_24M),
		.rst      (rst),
		.palValid (palValid),
		.palWord  (palWord),
		.blank    (blankDly),
		.shadow   (sysFlags.shadow),
		.rgb      (rgb),
		.vidValid (vidValid)
	);

endmodule

`default_nettype wire

//--- src/videoOut.sv
`timescale 1ns/1ps
`default_nettype none

module videoOut (
	input wire CLK_24M,
	input wire rst,
	input wire palValid,
	input wire neoVideoPkg::colorWordT palWord,
	input wire blank,
	input wire shadow,
	output neoVideoPkg::rgbT rgb,
	output logic vidValid
);

	neoVideoPkg::chanColorT redBits;
	neoVideoPkg::chanColorT greenBits;
	neoVideoPkg::chanColorT blueBits;
	logic darkN;
	logic shadowN;
	neoVideoPkg::rgbT rgbNext;

	// Ladder taps, MSB first
	// Five colour resistors, then dark, then shadow
	function automatic neoVideoPkg::levelT ladderLevel(
		input neoVideoPkg::chanColorT colorBits,
		input logic darkTap,
		input logic shadowTap
	);
		return {colorBits, darkTap, shadowTap};
	endfunction

	// Channel unpack, upper nibble joined with its LSB
	assign redBits = {
		palWord[neoVideoPkg::R_HI_LSB +: neoVideoPkg::CHAN_HI_W],
		palWord[neoVideoPkg::R_LSB_BIT]
	};
	assign greenBits = {
		palWord[neoVideoPkg::G_HI_LSB +: neoVideoPkg::CHAN_HI_W],
		palWord[neoVideoPkg::G_LSB_BIT]
	};
	assign blueBits = {
		palWord[neoVideoPkg::B_HI_LSB +: neoVideoPkg::CHAN_HI_W],
		palWord[neoVideoPkg::B_LSB_BIT]
	};

	// Dark and shadow pull their taps low when set
	assign darkN = ~palWord[neoVideoPkg::DARK_BIT];
	assign shadowN = ~shadow;

	// Level build, blanking wins over everything
	always_comb begin
		if (blank) begin
			rgbNext = '0;
		end else begin
			rgbNext.r = ladderLevel(redBits, darkN, shadowN);
			rgbNext.g = ladderLevel(greenBits, darkN, shadowN);
			rgbNext.b = ladderLevel(blueBits, darkN, shadowN);
		end
	end

	// Output register, second pipeline stage
	// Shadow is taken here, one edge after the palette read
	always_ff @(posedge CLK_24M) begin
		if (rst) begin
			rgb <= '0;
			vidValid <= 1'b0;
		end else begin
			vidValid <= palValid;
			// Last pixel stays on the pins between strobes
			if (palValid)
				rgb <= rgbNext;
		end
	end

endmodule

`default_nettype wire

//--- src/palRam.sv
`timescale 1ns/1ps
`default_nettype none

module palRam (
	input wire CLK_24M,
	input wire rst,
	input wire bank,
	input wire neoVideoPkg::cpuReqT cpuReq,
	output neoVideoPkg::colorWordT cpuRdData,
	output logic cpuRdValid,
	input wire pixStrobe,
	input wire neoVideoPkg::palIndexT pixIndex,
	output neoVideoPkg::colorWordT palWord,
	output logic palValid
);

	// Both banks in one array, bank bit on top
	neoVideoPkg::colorWordT palMem [neoVideoPkg::PAL_WORDS];

	neoVideoPkg::palAddrT cpuAddr;
	neoVideoPkg::palAddrT pixAddr;

	// Current bank applies to both ports
	assign cpuAddr = {bank, cpuReq.addr};
	assign pixAddr = {bank, pixIndex};

	// Write port and two registered read ports
	// Reads see the word before a same-edge write
	always_ff @(posedge CLK_24M) begin
		if (cpuReq.we)
			palMem[cpuAddr] <= cpuReq.wrData;
		// CPU readback
		if (cpuReq.rd)
			cpuRdData <= palMem[cpuAddr];
		// Pixel lookup, held between strobes
		if (pixStrobe)
			palWord <= palMem[pixAddr];
	end

	// Valid flags, one cycle behind their strobes
	always_ff @(posedge CLK_24M) begin
		if (rst) begin
			cpuRdValid <= 1'b0;
			palValid <= 1'b0;
		end else begin
			cpuRdValid <= cpuReq.rd;
			palValid <= pixStrobe;
		end
	end

endmodule

`default_nettype wire

//--- src/sysLatch.sv
`timescale 1ns/1ps
`default_nettype none

module sysLatch (
	input wire CLK_24M,
	input wire rst,
	input wire latchWe,
	input wire neoVideoPkg::latchAddrT latchAddr,
	output neoVideoPkg::sysFlagsT sysFlags
);

	neoVideoPkg::latchSelT latchSel;
	logic latchData;
	logic [neoVideoPkg::LATCH_FLAGS-1:0] selDecode;
	logic [neoVideoPkg::LATCH_FLAGS-1:0] flagBits;

	// A3..A1 pick the output, A4 is the value
	assign latchSel = latchAddr[neoVideoPkg::LATCH_SEL_W-1:0];
	assign latchData = latchAddr[neoVideoPkg::LATCH_DATA_BIT];

	// One-hot output enable, only while strobed
	always_comb begin
		selDecode = '0;
		if (latchWe)
			selDecode[latchSel] = 1'b1;
	end

	// Addressable latch cells
	// Unselected cells hold, as on the 259
	always_ff @(posedge CLK_24M) begin
		if (rst) begin
			flagBits <= '0;
		end else begin
			for (int i = 0; i < neoVideoPkg::LATCH_FLAGS; i++) begin
				if (selDecode[i])
					flagBits[i] <= latchData;
			end
		end
	end

	// Bit order matches the flag struct, palBnk on Q7
	assign sysFlags = neoVideoPkg::sysFlagsT'(flagBits);

endmodule

`default_nettype wire

//--- src/neoVideoPkg.sv
`default_nettype none

package neoVideoPkg;

	// System latch addressing, copy of 68K A4..A1
	localparam int LATCH_ADDR_W = 4;
	localparam int LATCH_SEL_W = 3;
	// Latch data value rides on A4
	localparam int LATCH_DATA_BIT = 3;
	localparam int LATCH_FLAGS = 1 << LATCH_SEL_W;

	// Palette geometry
	localparam int PAL_BANK_WORDS = 4096;
	localparam int PAL_BANKS = 2;
	localparam int PAL_WORDS = PAL_BANKS * PAL_BANK_WORDS;
	localparam int PAL_INDEX_W = $clog2(PAL_BANK_WORDS);
	localparam int PAL_ADDR_W = $clog2(PAL_WORDS);

	// Colour word layout
	localparam int COLOR_W = 16;
	localparam int DARK_BIT = 15;
	localparam int R_LSB_BIT = 14;
	localparam int G_LSB_BIT = 13;
	localparam int B_LSB_BIT = 12;
	// Upper nibbles, low bit position of each
	localparam int R_HI_LSB = 8;
	localparam int G_HI_LSB = 4;
	localparam int B_HI_LSB = 0;
	localparam int CHAN_HI_W = 4;

	// Resistor ladder output
	localparam int LEVEL_W = 7;

	typedef logic [PAL_INDEX_W-1:0] palIndexT;
	typedef logic [PAL_ADDR_W-1:0] palAddrT;
	typedef logic [COLOR_W-1:0] colorWordT;
	typedef logic [LEVEL_W-1:0] levelT;
	// Five colour bits of one channel, upper nibble then LSB
	typedef logic [CHAN_HI_W:0] chanColorT;
	typedef logic [LATCH_ADDR_W-1:0] latchAddrT;
	typedef logic [LATCH_SEL_W-1:0] latchSelT;

	typedef struct packed {
		levelT r;
		levelT g;
		levelT b;
	} rgbT;

	// One pixel from the line buffer side
	typedef struct packed {
		palIndexT index;
		logic blank;
	} pixReqT;

	// 68K palette access, we and rd never together
	typedef struct packed {
		palIndexT addr;
		colorWordT wrData;
		logic we;
		logic rd;
	} cpuReqT;

	// Latch outputs, Q7 down to Q0
	typedef struct packed {
		logic palBnk;
		logic nSramWen;
		logic nSystem;
		logic nRegEn;
		logic cardWenB;
		logic nCardWen;
		logic nVec;
		logic shadow;
	} sysFlagsT;

endpackage

`default_nettype wire
